/* design/fpu_add.sv */
// FPU adder datapath
`timescale 1ns/100ps

module fpu_add
   import fpu_format_pkg::*;
(
   input  fp32_t    a,
   input  fp32_t    b,
   output prenorm_t sum
);

   // Operands ordered by magnitude
   fp32_t       larger;
   fp32_t       smaller;

   // Mantissas in prenorm layout
   logic [47:0] mant_big;
   logic [47:0] mant_sml;

   // Alignment
   logic [7:0]  exp_diff;
   logic [5:0]  shamt;
   logic [95:0] shift_ext;
   logic [47:0] mant_aligned;

   logic        eff_sub;

   ////////////////////////////////
   // Operand swap
   ////////////////////////////////

   // Exponent and fraction compare as one magnitude
   always_comb
   begin
      if ({b.exponent, b.fraction} > {a.exponent, a.fraction})
      begin
         larger  = b;
         smaller = a;
      end
      else
      begin
         larger  = a;
         smaller = b;
      end
   end

   // Hidden bit at 46, low bits as guard room
   assign mant_big = {1'b0, |larger.exponent, larger.fraction, {FRAC_W{1'b0}}};
   assign mant_sml = {1'b0, |smaller.exponent, smaller.fraction, {FRAC_W{1'b0}}};

   ////////////////////////////////
   // Alignment
   ////////////////////////////////

   assign exp_diff = larger.exponent - smaller.exponent;
   // Past 48 everything is sticky anyway
   assign shamt = (exp_diff > 8'd63) ? 6'd63 : exp_diff[5:0];

   // Lower half catches the bits shifted out
   assign shift_ext = {mant_sml, 48'b0} >> shamt;
   // Lost bits jammed into LSB
   assign mant_aligned = shift_ext[95:48] | {47'b0, |shift_ext[47:0]};

   ////////////////////////////////
   // Add or subtract
   ////////////////////////////////

   // Opposite signs mean magnitude subtraction
   assign eff_sub = a.sign ^ b.sign;

   assign sum.sign     = larger.sign;
   assign sum.exponent = {2'b00, larger.exponent};
   // No borrow, larger magnitude comes first
   assign sum.mantissa = eff_sub ? (mant_big - mant_aligned)
                                 : (mant_big + mant_aligned);

endmodule

/* design/fpu_core.sv */
// FPU core top level
// Input register and datapath select
`timescale 1ns/100ps

module fpu_core
   import fpu_format_pkg::*;
   import fpu_ctrl_pkg::*;
(
   input  logic       Clk_CI,
   input  logic       Rst_RBI,
   input  fpu_req_t   req,
   input  logic       stall,
   output fp32_t      result,
   output fpu_flags_t flags
);

   // Registered request
   fpu_req_t   req_q;

   // Flushed operands
   fp32_t      op_a;
   fp32_t      op_b;

   // Datapath results
   prenorm_t   sum;
   prenorm_t   prod;
   prenorm_t   pre_norm;
   fp32_t      norm_res;
   logic       rounded;
   logic       exp_of;
   logic       exp_uf;
   fpu_flags_t exc_flags;
   fp32_t      final_res;

   ////////////////////////////////
   // Input register
   ////////////////////////////////

   // Holds under stall
   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
         req_q <= '0;
      else if (~stall)
         req_q <= req;
   end

   // Subnormals become signed zero
   // Subtraction as addition with b negated
   always_comb
   begin
      op_a = req_q.a;
      op_b = req_q.b;
      if (req_q.a.exponent == 8'h00)
         op_a.fraction = '0;
      if (req_q.b.exponent == 8'h00)
         op_b.fraction = '0;
      if (req_q.op == OP_SUB)
         op_b.sign = ~op_b.sign;
   end

   ////////////////////////////////
   // Datapath
   ////////////////////////////////

   fpu_add u_fpu_add
   (
      .a   (op_a),
      .b   (op_b),
      .sum (sum)
   );

   fpu_mult u_fpu_mult
   (
      .a    (op_a),
      .b    (op_b),
      .prod (prod)
   );

   // Add path also covers sub
   assign pre_norm = (req_q.op == OP_MUL) ? prod : sum;

   fpu_norm u_fpu_norm
   (
      .value   (pre_norm),
      .rm      (req_q.rm),
      .res     (norm_res),
      .rounded (rounded),
      .exp_of  (exp_of),
      .exp_uf  (exp_uf)
   );

   // Raw registered operands, classes decoded inside
   fpu_except u_fpu_except
   (
      .req       (req_q),
      .res       (norm_res),
      .rounded   (rounded),
      .exp_of    (exp_of),
      .exp_uf    (exp_uf),
      .flags     (exc_flags),
      .final_res (final_res)
   );

   // Idle request shows all zeros
   assign result = req_q.enable ? final_res : '0;
   assign flags  = req_q.enable ? exc_flags : '0;

endmodule

/* design/fpu_ctrl_pkg.sv */
// FPU control definitions
package fpu_ctrl_pkg;
   import fpu_format_pkg::*;

   // Operation codes, 2'b11 unused
   typedef enum logic [1:0] {
      OP_ADD = 2'b00,
      OP_SUB = 2'b01,
      OP_MUL = 2'b10
   } fp_op_e;

   // Rounding modes
   typedef enum logic [1:0] {
      RM_RNE = 2'b00,
      RM_RTZ = 2'b01,
      RM_RUP = 2'b10,
      RM_RDN = 2'b11
   } rm_e;

   // One request, rounding mode travels with it
   typedef struct packed {
      logic   enable;
      fp_op_e op;
      rm_e    rm;
      fp32_t  a;
      fp32_t  b;
   } fpu_req_t;

   // Status flags of one result
   typedef struct packed {
      logic of;
      logic uf;
      logic zero;
      logic ix;
      logic iv;
      logic inf;
   } fpu_flags_t;

endpackage

/* design/fpu_except.sv */
// FPU special cases and flags
`timescale 1ns/100ps

module fpu_except
   import fpu_format_pkg::*;
   import fpu_ctrl_pkg::*;
(
   input  fpu_req_t   req,
   input  fp32_t      res,
   input  logic       rounded,
   input  logic       exp_of,
   input  logic       exp_uf,
   output fpu_flags_t flags,
   output fp32_t      final_res
);

   // Operand classes, subnormals count as zero
   logic a_nan;
   logic b_nan;
   logic a_inf;
   logic b_inf;
   logic a_zero;
   logic b_zero;

   logic is_mul;
   logic sign_b;
   logic invalid;
   logic exact_zero;
   logic ovf_to_inf;

   assign a_nan  = (req.a.exponent == EXP_MAX) & (|req.a.fraction);
   assign b_nan  = (req.b.exponent == EXP_MAX) & (|req.b.fraction);
   assign a_inf  = (req.a.exponent == EXP_MAX) & ~(|req.a.fraction);
   assign b_inf  = (req.b.exponent == EXP_MAX) & ~(|req.b.fraction);
   assign a_zero = (req.a.exponent == 8'h00);
   assign b_zero = (req.b.exponent == 8'h00);

   assign is_mul = (req.op == OP_MUL);
   // Effective sign of b, flipped for subtraction
   assign sign_b = req.b.sign ^ (req.op == OP_SUB);

   // NaN in, Inf minus Inf, zero times Inf
   assign invalid = a_nan | b_nan
                  | (~is_mul & a_inf & b_inf & (req.a.sign ^ sign_b))
                  | (is_mul & ((a_inf & b_zero) | (a_zero & b_inf)));

   // In range with exponent 0 only for a zero mantissa
   assign exact_zero = ~exp_of & ~exp_uf & (res.exponent == 8'h00);

   // Overflow saturates toward zero in the other modes
   assign ovf_to_inf = (req.rm == RM_RNE)
                     | ((req.rm == RM_RUP) & ~res.sign)
                     | ((req.rm == RM_RDN) & res.sign);

   ////////////////////////////////
   // Overrides, by priority
   ////////////////////////////////

   always_comb
   begin
      final_res = res;
      flags     = '0;
      if (invalid)
      begin
         final_res = QNAN;
         flags.iv  = 1'b1;
      end
      else if (a_inf | b_inf)
      begin
         // Inf passes on, sign from the infinite operand
         final_res.sign     = is_mul ? (req.a.sign ^ req.b.sign)
                                     : (a_inf ? req.a.sign : sign_b);
         final_res.exponent = 8'(EXP_MAX);
         final_res.fraction = '0;
         flags.inf          = 1'b1;
      end
      else if (exact_zero)
      begin
         final_res      = '0;
         final_res.sign = (req.rm == RM_RDN);
         flags.zero     = 1'b1;
      end
      else if (exp_of)
      begin
         // Inf, or largest finite of the same sign
         final_res.exponent = ovf_to_inf ? 8'(EXP_MAX) : 8'(EXP_MAX - 1);
         final_res.fraction = ovf_to_inf ? 23'h0 : 23'h7fffff;
         flags.of           = 1'b1;
         flags.ix           = 1'b1;
         flags.inf          = ovf_to_inf;
      end
      else if (exp_uf)
      begin
         // Flush to zero, sign kept
         final_res.exponent = '0;
         final_res.fraction = '0;
         flags.uf           = 1'b1;
         flags.ix           = 1'b1;
         flags.zero         = 1'b1;
      end
      else
         flags.ix = rounded;
   end

endmodule

/* design/fpu_format_pkg.sv */
// Float format definitions
// Single-precision word layout and pre-normalized value
package fpu_format_pkg;

   ////////////////////////////////
   // Field widths
   ////////////////////////////////

   // IEEE single-precision fields
   localparam int EXP_W  = 8;
   localparam int FRAC_W = 23;

   // Unrounded mantissa, binary point after bit 46
   localparam int MANT_W = 48;
   // Signed exponent, room for mult range and carry
   localparam int PEXP_W = 10;

   ////////////////////////////////
   // Constants
   ////////////////////////////////

   localparam int EXP_BIAS = 127;
   // All-ones exponent, Inf or NaN
   localparam int EXP_MAX  = 255;

   // Float word, sign on top
   typedef struct packed {
      logic              sign;
      logic [EXP_W-1:0]  exponent;
      logic [FRAC_W-1:0] fraction;
   } fp32_t;

   // The only NaN ever produced
   localparam fp32_t QNAN = 32'h7fc00000;

   // Adder or multiplier output ahead of rounding
   // Bit 47 is carry room, bit 46 weighs 2^0
   typedef struct packed {
      logic                     sign;
      logic signed [PEXP_W-1:0] exponent;
      logic [MANT_W-1:0]        mantissa;
   } prenorm_t;

endpackage

/* design/fpu_mult.sv */
// FPU multiplier datapath
`timescale 1ns/100ps

module fpu_mult
   import fpu_format_pkg::*;
(
   input  fp32_t    a,
   input  fp32_t    b,
   output prenorm_t prod
);

   // Mantissas with hidden bit
   logic [23:0] mant_a;
   logic [23:0] mant_b;

   // Zero exponent means zero, hidden bit drops
   assign mant_a = {|a.exponent, a.fraction};
   assign mant_b = {|b.exponent, b.fraction};

   // Sign of product
   assign prod.sign = a.sign ^ b.sign;

   // Biased exponent sum, may go negative
   assign prod.exponent = 10'(int'(a.exponent) + int'(b.exponent) - EXP_BIAS);

   // 1.23 times 1.23 gives 2.46, point lands after bit 46
   // Product in [1,4), bit 47 set when it reaches 2
   assign prod.mantissa = mant_a * mant_b;

endmodule

/* design/fpu_norm.sv */
// FPU normalizer and rounder
`timescale 1ns/100ps

module fpu_norm
   import fpu_format_pkg::*;
   import fpu_ctrl_pkg::*;
(
   input  prenorm_t value,
   input  rm_e      rm,
   output fp32_t    res,
   output logic     rounded,
   output logic     exp_of,
   output logic     exp_uf
);

   // Normalization
   logic [5:0]        lead_zeros;
   logic [47:0]       mant_shift;
   logic signed [9:0] exp_norm;
   logic              is_zero;

   // Rounding
   logic [23:0]       mant_trunc;
   logic              guard;
   logic              sticky;
   logic              round_up;
   logic [24:0]       mant_sum;
   logic signed [9:0] exp_rnd;

   ////////////////////////////////
   // Leading zero count
   ////////////////////////////////

   // Highest set bit is the last one written
   always_comb
   begin
      lead_zeros = '0;
      for (int i = 0; i < 48; i++)
      begin
         if (value.mantissa[i])
            lead_zeros = 6'(47 - i);
      end
   end

   assign is_zero = ~|value.mantissa;

   // Leading one moved up to bit 47, nothing lost
   assign mant_shift = value.mantissa << lead_zeros;
   // Bit 47 weighs 2^1 in input scale
   assign exp_norm = value.exponent + 10'sd1 - $signed({4'b0000, lead_zeros});

   ////////////////////////////////
   // Rounding
   ////////////////////////////////

   // 24 kept bits, then guard and sticky
   assign mant_trunc = mant_shift[47:24];
   assign guard      = mant_shift[23];
   assign sticky     = |mant_shift[22:0];

   always_comb
   begin
      case (rm)
         // Ties go to even
         RM_RNE: round_up = guard & (sticky | mant_trunc[0]);
         RM_RTZ: round_up = 1'b0;
         // Directed modes bump away from zero on their side
         RM_RUP: round_up = (guard | sticky) & ~value.sign;
         RM_RDN: round_up = (guard | sticky) & value.sign;
      endcase
   end

   assign mant_sum = {1'b0, mant_trunc} + 25'(round_up);

   // Carry out leaves 1.000, low bits are zero in both cases
   assign exp_rnd = exp_norm + $signed({9'b0, mant_sum[24]});

   ////////////////////////////////
   // Result and range check
   ////////////////////////////////

   assign res.sign     = value.sign;
   // Zero mantissa gives exponent 0 and no range flags
   assign res.exponent = is_zero ? 8'h00 : exp_rnd[7:0];
   assign res.fraction = is_zero ? 23'h0 : mant_sum[22:0];

   // Any discarded bit makes the result inexact
   assign rounded = guard | sticky;

   // Tininess judged after rounding
   assign exp_of = ~is_zero & (exp_rnd >= EXP_MAX);
   assign exp_uf = ~is_zero & (exp_rnd <= 0);

endmodule

/* project.f */
+incdir+verif
design/fpu_format_pkg.sv
design/fpu_ctrl_pkg.sv
design/fpu_add.sv
design/fpu_mult.sv
design/fpu_norm.sv
design/fpu_except.sv
design/fpu_core.sv
verif/fpu_tb.sv

/* verif/fpu_model.svh */
// FPU reference model
// Random source and typed compare tasks
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

////////////////////////////////
// Random source
////////////////////////////////

// Galois taps, x^32+x^22+x^2+x+1
localparam logic [31:0] LFSR_TAPS = 32'h80200003;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
endfunction

// One LFSR step per bit, output bit shifted in at the bottom
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int k = 0; k < n; k++)
   begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
   end
   return v;
endfunction

////////////////////////////////
// Arithmetic model
////////////////////////////////

// Exact value is mag * 2^(ebase - 150), rounded to 24 bits
task automatic round_exact(input logic sgn, input logic [299:0] mag, input int ebase,
                           input rm_e rm, output fp32_t res, output fpu_flags_t fl);
   int          msb;
   int          sh;
   int          e_fin;
   logic [24:0] m;
   logic        guard;
   logic        sticky;
   logic        up;
   logic        to_inf;
   res    = '0;
   fl     = '0;
   msb    = 0;
   guard  = 1'b0;
   sticky = 1'b0;
   for (int k = 0; k < 300; k++)
      if (mag[k])
         msb = k;
   sh = msb - 23;
   if (mag == '0)
   begin
      // Exact zero, negative only when rounding down
      res.sign = (rm == RM_RDN);
      fl.zero  = 1'b1;
   end
   else
   begin
      if (sh > 0)
      begin
         m      = 25'(mag >> sh);
         guard  = mag[sh-1];
         sticky = (mag & ((300'(1) << (sh - 1)) - 300'(1))) != '0;
      end
      else
         m = 25'(mag << (-sh));
      case (rm)
         RM_RNE:  up = guard & (sticky | m[0]);
         RM_RTZ:  up = 1'b0;
         RM_RUP:  up = (guard | sticky) & ~sgn;
         default: up = (guard | sticky) & sgn;
      endcase
      m     = m + 25'(up);
      e_fin = ebase + sh;
      // Rounding carried into a new binade
      if (m[24])
      begin
         m     = m >> 1;
         e_fin = e_fin + 1;
      end
      to_inf = (rm == RM_RNE) || (rm == RM_RUP && !sgn) || (rm == RM_RDN && sgn);
      if (e_fin >= 255)
      begin
         res    = to_inf ? {sgn, 8'hff, 23'h0} : {sgn, 8'hfe, 23'h7fffff};
         fl.of  = 1'b1;
         fl.ix  = 1'b1;
         fl.inf = to_inf;
      end
      else if (e_fin <= 0)
      begin
         // Tiny after rounding, flushed
         res     = {sgn, 31'h0};
         fl.uf   = 1'b1;
         fl.ix   = 1'b1;
         fl.zero = 1'b1;
      end
      else
      begin
         res   = {sgn, 8'(e_fin), m[22:0]};
         fl.ix = guard | sticky;
      end
   end
endtask

task automatic compute_expected(input fpu_req_t r, output fp32_t res, output fpu_flags_t fl);
   logic         sa, sb;
   logic         a_nan, b_nan;
   logic         a_inf, b_inf;
   logic         a_zero, b_zero;
   logic         is_mul;
   logic         sgn;
   logic [23:0]  ma, mb;
   logic [299:0] wa, wb, mag;
   int           ea, eb, ebase;
   res    = '0;
   fl     = '0;
   is_mul = (r.op == OP_MUL);
   sa     = r.a.sign;
   // Effective sign of b
   sb     = r.b.sign ^ (r.op == OP_SUB);
   a_zero = (r.a.exponent == 8'h00);
   b_zero = (r.b.exponent == 8'h00);
   a_inf  = (r.a.exponent == 8'hff) && (r.a.fraction == '0);
   b_inf  = (r.b.exponent == 8'hff) && (r.b.fraction == '0);
   a_nan  = (r.a.exponent == 8'hff) && (r.a.fraction != '0);
   b_nan  = (r.b.exponent == 8'hff) && (r.b.fraction != '0);
   // Subnormals count as zero
   ma     = a_zero ? 24'h0 : {1'b1, r.a.fraction};
   mb     = b_zero ? 24'h0 : {1'b1, r.b.fraction};
   ea     = a_zero ? 1 : int'(r.a.exponent);
   eb     = b_zero ? 1 : int'(r.b.exponent);
   if (!r.enable)
      res = '0;
   else if (a_nan || b_nan || (!is_mul && a_inf && b_inf && (sa != sb))
            || (is_mul && ((a_inf && b_zero) || (a_zero && b_inf))))
   begin
      res   = QNAN;
      fl.iv = 1'b1;
   end
   else if (a_inf || b_inf)
   begin
      res    = {(is_mul ? (sa ^ sb) : (a_inf ? sa : sb)), 8'hff, 23'h0};
      fl.inf = 1'b1;
   end
   else
   begin
      if (is_mul)
      begin
         mag   = 300'(ma) * 300'(mb);
         ebase = ea + eb - 150;
         sgn   = sa ^ sb;
      end
      else
      begin
         // Align both on the smaller exponent, nothing is lost
         ebase = (ea < eb) ? ea : eb;
         wa    = 300'(ma) << (ea - ebase);
         wb    = 300'(mb) << (eb - ebase);
         if (sa == sb)
         begin
            mag = wa + wb;
            sgn = sa;
         end
         else if (wa >= wb)
         begin
            mag = wa - wb;
            sgn = sa;
         end
         else
         begin
            mag = wb - wa;
            sgn = sb;
         end
      end
      round_exact(sgn, mag, ebase, r.rm, res, fl);
   end
endtask

////////////////////////////////
// Compare tasks
////////////////////////////////

task automatic check_result(input fp32_t got, input fp32_t expected, input string name);
   if (got !== expected)
   begin
      $display("MISMATCH %s: got %h, expected %h", name, got, expected);
      $display("Something failed");
      $fatal(1, "Result compare error");
   end
endtask

task automatic check_flags(input fpu_flags_t got, input fpu_flags_t expected,
                           input string name);
   if (got !== expected)
   begin
      $display("MISMATCH %s: got %h, expected %h", name, got, expected);
      $display("Something failed");
      $fatal(1, "Flag compare error");
   end
endtask

`endif

/* verif/fpu_tb.sv */
// FPU core testbench
`timescale 1ns/100ps

module fpu_tb
   import fpu_format_pkg::*;
   import fpu_ctrl_pkg::*;
();

   localparam int          NUM_TESTS      = 4000;
   localparam logic [31:0] SEED           = 32'ha51e092f;
   localparam int          TIMEOUT_CYCLES = NUM_TESTS * 4 + 100;

   logic        Clk_CI;
   logic        Rst_RBI;
   fpu_req_t    req;
   logic        stall;
   fp32_t       result;
   fpu_flags_t  flags;

   // LFSR state
   logic [31:0] lfsr_q;
   // Request the DUT register should hold now
   fpu_req_t    held;
   fpu_req_t    req_d;
   logic        stall_d;
   fp32_t       exp_res;
   fpu_flags_t  exp_flags;
   int          cycle_cnt = 0;

   `include "fpu_model.svh"

   fpu_core u_fpu_core
   (
      .Clk_CI  (Clk_CI),
      .Rst_RBI (Rst_RBI),
      .req     (req),
      .stall   (stall),
      .result  (result),
      .flags   (flags)
   );

   ////////////////////////////////
   // Stimulus generation
   ////////////////////////////////

   // Biased toward zero, Inf/NaN and the exponent ends
   function automatic fp32_t make_operand();
      fp32_t      f;
      logic [2:0] cls;
      cls        = 3'(rand_bits(3));
      f.sign     = 1'(rand_bits(1));
      f.fraction = 23'(rand_bits(23));
      case (cls)
         3'd0:
         begin
            f.exponent = 8'h00;
            if (rand_bits(1) == 1)
               f.fraction = '0;
         end
         3'd1:
         begin
            f.exponent = 8'hff;
            if (rand_bits(1) == 1)
               f.fraction = '0;
         end
         3'd2:    f.exponent = 8'd254 - 8'(rand_bits(2));
         3'd3:    f.exponent = 8'd1 + 8'(rand_bits(2));
         default:
         begin
            f.exponent = 8'(rand_bits(8));
            if (f.exponent == 8'h00 || f.exponent == 8'hff)
               f.exponent = 8'd127;
         end
      endcase
      return f;
   endfunction

   function automatic fpu_req_t make_request();
      fpu_req_t   r;
      logic [1:0] op_bits;
      r.enable = (rand_bits(3) != 0);
      op_bits  = 2'(rand_bits(2));
      r.op     = (op_bits == 2'b11) ? OP_SUB : fp_op_e'(op_bits);
      r.rm     = rm_e'(2'(rand_bits(2)));
      r.a      = make_operand();
      // Equal magnitudes for cancellation
      if (rand_bits(2) == 0)
      begin
         r.b      = r.a;
         r.b.sign = 1'(rand_bits(1));
      end
      else
         r.b = make_operand();
      return r;
   endfunction

   ////////////////////////////////
   // Clock and timeout
   ////////////////////////////////

   initial
   begin
      Clk_CI = 1'b0;
      forever #4 Clk_CI = ~Clk_CI;
   end

   always @(posedge Clk_CI)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Something failed");
         $fatal(1, "Timeout");
      end
   end

   ////////////////////////////////
   // Main sequence
   ////////////////////////////////

   initial
   begin
      lfsr_q  = SEED;
      Rst_RBI = 1'b0;
      stall   = 1'b0;
      req     = '0;
      held    = '0;
      // Outputs idle throughout reset under enabled requests
      repeat (5)
      begin
         @(negedge Clk_CI);
         check_result(result, '0, "result");
         check_flags(flags, '0, "flags");
         req_d        = make_request();
         req_d.enable = 1'b1;
         req          = req_d;
      end
      Rst_RBI = 1'b1;
      // Last request driven in reset is the first one sampled
      held    = req_d;
      for (int i = 0; i < NUM_TESTS; i++)
      begin
         @(negedge Clk_CI);
         compute_expected(held, exp_res, exp_flags);
         check_result(result, exp_res, "result");
         check_flags(flags, exp_flags, "flags");
         req_d   = make_request();
         stall_d = (rand_bits(2) == 0);
         req     = req_d;
         stall   = stall_d;
         // Register takes the request only without stall
         if (!stall_d)
            held = req_d;
      end
      @(negedge Clk_CI);
      compute_expected(held, exp_res, exp_flags);
      check_result(result, exp_res, "result");
      check_flags(flags, exp_flags, "flags");
      $display("Everything OK");
      $finish;
   end

endmodule
